//--- verilog/iw_pkg.sv
package iw_pkg;

    // datapath widths
    localparam int WORD_W  = 32;
    localparam int VREG_W  = 6;
    localparam int PREG_W  = 7;
    localparam int CTX_W   = 4;
    localparam int FUNCT_W = 10;

    // execution class of a decoded instruction
    typedef enum logic [1:0] {
        OP_ALU     = 2'd0,
        OP_ALU_IMM = 2'd1,
        OP_MEM     = 2'd2,
        OP_JUMP    = 2'd3
    } opcode_t;

    // instruction as delivered by the decoder
    typedef struct packed {
        opcode_t             opcode;
        // func3/func7 bits, carried through to execute untouched
        logic [FUNCT_W-1:0]  funct;
        logic [WORD_W-1:0]   imm;
        logic                rs1_need;
        logic [VREG_W-1:0]   rs1_tag;
        logic                rs2_need;
        logic [VREG_W-1:0]   rs2_tag;
        logic                rd_need;
        logic [VREG_W-1:0]   rd_tag;
        logic [CTX_W-1:0]    ctx;
    } dec_entry_t;

    // one window slot, decoder fields plus resolution state
    typedef struct packed {
        logic                valid;
        opcode_t             opcode;
        logic [FUNCT_W-1:0]  funct;
        logic [WORD_W-1:0]   imm;
        logic                rs1_need;
        logic [VREG_W-1:0]   rs1_tag;
        logic                rs2_need;
        logic [VREG_W-1:0]   rs2_tag;
        logic                rd_need;
        logic [VREG_W-1:0]   rd_tag;
        logic [CTX_W-1:0]    ctx;
        logic                rs1_rdy;
        logic                rs2_rdy;
        logic                rd_rdy;
        logic [WORD_W-1:0]   d_rs1;
        logic [WORD_W-1:0]   d_rs2;
        logic [PREG_W-1:0]   pa_rd;
    } iw_entry_t;

    // lookup request for one head slot
    typedef struct packed {
        logic                valid;
        logic                rs1_need;
        logic [VREG_W-1:0]   rs1_tag;
        logic                rs2_need;
        logic [VREG_W-1:0]   rs2_tag;
        logic                rd_need;
        logic [VREG_W-1:0]   rd_tag;
        logic [CTX_W-1:0]    ctx;
    } reg_req_t;

    // register manager answer, same cycle as the request
    typedef struct packed {
        logic                rs1_ready;
        logic [WORD_W-1:0]   rs1_value;
        logic                rs2_ready;
        logic [WORD_W-1:0]   rs2_value;
        logic                rd_ready;
        logic [PREG_W-1:0]   pa_rd;
    } reg_resp_t;

    // operation handed to execute
    typedef struct packed {
        opcode_t             opcode;
        logic [FUNCT_W-1:0]  funct;
        logic [WORD_W-1:0]   d_rs1;
        logic [WORD_W-1:0]   d_rs2;
        logic [PREG_W-1:0]   pa_rd;
        logic [CTX_W-1:0]    ctx;
    } issue_op_t;

endpackage

//--- verilog/operand_resolve.sv
`timescale 1ns/1ps

module operand_resolve
    import iw_pkg::*;
#(
    parameter int WINDOW_SIZE   = 8,
    parameter int RESOLVE_SLOTS = 4
) (
    input  iw_entry_t [WINDOW_SIZE-1:0]   slots,
    output reg_req_t  [RESOLVE_SLOTS-1:0] reg_req,
    input  reg_resp_t [RESOLVE_SLOTS-1:0] reg_resp,
    output iw_entry_t [WINDOW_SIZE-1:0]   resolved
);

    logic [RESOLVE_SLOTS-1:0] rs1_hit;
    logic [RESOLVE_SLOTS-1:0] rs2_hit;
    logic [RESOLVE_SLOTS-1:0] rd_hit;
    logic [RESOLVE_SLOTS-1:0] addr_op;
    logic [WORD_W-1:0]        rs1_sum [RESOLVE_SLOTS];

    // requests for the head slots, only operands still open
    always_comb begin
        for (int i = 0; i < RESOLVE_SLOTS; i++) begin
            reg_req[i].valid    = slots[i].valid;
            reg_req[i].rs1_need = slots[i].valid & slots[i].rs1_need & ~slots[i].rs1_rdy;
            reg_req[i].rs1_tag  = slots[i].rs1_tag;
            reg_req[i].rs2_need = slots[i].valid & slots[i].rs2_need & ~slots[i].rs2_rdy;
            reg_req[i].rs2_tag  = slots[i].rs2_tag;
            reg_req[i].rd_need  = slots[i].valid & slots[i].rd_need & ~slots[i].rd_rdy;
            reg_req[i].rd_tag   = slots[i].rd_tag;
            reg_req[i].ctx      = slots[i].ctx;
        end
    end

    // a reply bit only counts against an open request
    for (genvar i = 0; i < RESOLVE_SLOTS; i++) begin : g_hit
        assign rs1_hit[i] = reg_req[i].rs1_need & reg_resp[i].rs1_ready;
        assign rs2_hit[i] = reg_req[i].rs2_need & reg_resp[i].rs2_ready;
        assign rd_hit[i]  = reg_req[i].rd_need & reg_resp[i].rd_ready;

        // loads, stores and jumps carry base plus offset in d_rs1
        assign addr_op[i] = (slots[i].opcode == OP_MEM) || (slots[i].opcode == OP_JUMP);
        assign rs1_sum[i] = addr_op[i] ? reg_resp[i].rs1_value + slots[i].imm
                                       : reg_resp[i].rs1_value;
    end

    // merge replies, slots past the resolve range keep their state
    always_comb begin
        resolved = slots;
        for (int i = 0; i < RESOLVE_SLOTS; i++) begin
            if (rs1_hit[i]) begin
                resolved[i].rs1_rdy = 1'b1;
                resolved[i].d_rs1   = rs1_sum[i];
            end
            if (rs2_hit[i]) begin
                resolved[i].rs2_rdy = 1'b1;
                resolved[i].d_rs2   = reg_resp[i].rs2_value;
            end
            if (rd_hit[i]) begin
                resolved[i].rd_rdy = 1'b1;
                resolved[i].pa_rd  = reg_resp[i].pa_rd;
            end
        end
    end

endmodule

//--- verilog/issue_select.sv
`timescale 1ns/1ps

module issue_select
    import iw_pkg::*;
#(
    parameter int WINDOW_SIZE = 8,
    parameter int ISSUE_SLOTS = 2
) (
    input  iw_entry_t [WINDOW_SIZE-1:0] slots,
    output logic                        issue_valid,
    output issue_op_t                   issue_op,
    output logic [WINDOW_SIZE-1:0]      issue_onehot
);

    logic [ISSUE_SLOTS-1:0] ready;
    // taken[i] means some slot below i already won
    logic [ISSUE_SLOTS:0]   taken;
    iw_entry_t              pick;

    assign taken[0] = 1'b0;

    // priority chain, lowest index is oldest
    for (genvar i = 0; i < ISSUE_SLOTS; i++) begin : g_chain
        assign ready[i] = slots[i].valid & slots[i].rs1_rdy
                        & slots[i].rs2_rdy & slots[i].rd_rdy;
        assign issue_onehot[i] = ready[i] & ~taken[i];
        assign taken[i+1]      = taken[i] | ready[i];
    end

    // slots beyond the issue range never go out directly
    if (WINDOW_SIZE > ISSUE_SLOTS) begin : g_rest
        assign issue_onehot[WINDOW_SIZE-1:ISSUE_SLOTS] = '0;
    end

    assign issue_valid = taken[ISSUE_SLOTS];

    always_comb begin
        pick = '0;
        for (int i = 0; i < ISSUE_SLOTS; i++) begin
            if (issue_onehot[i]) begin
                pick = slots[i];
            end
        end
    end

    always_comb begin
        issue_op.opcode = pick.opcode;
        issue_op.funct  = pick.funct;
        issue_op.d_rs1  = pick.d_rs1;
        issue_op.d_rs2  = pick.d_rs2;
        issue_op.pa_rd  = pick.pa_rd;
        issue_op.ctx    = pick.ctx;
    end

endmodule

//--- verilog/window_slots.sv
`timescale 1ns/1ps

module window_slots
    import iw_pkg::*;
#(
    parameter int WINDOW_SIZE = 8
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  iw_entry_t [WINDOW_SIZE-1:0] resolved,
    input  logic [WINDOW_SIZE-1:0]      issue_onehot,
    input  logic                        hazard_valid,
    input  logic [CTX_W-1:0]            hazard_mask,
    input  logic                        dec_valid,
    input  dec_entry_t                  dec_entry,
    output iw_entry_t [WINDOW_SIZE-1:0] slots,
    output logic                        accept_able
);

    localparam int IDX_W = (WINDOW_SIZE > 1) ? $clog2(WINDOW_SIZE) : 1;
    localparam int CNT_W = $clog2(WINDOW_SIZE + 1);

    logic [WINDOW_SIZE-1:0]      valid_q;
    iw_entry_t [WINDOW_SIZE-1:0] slot_q;

    logic [WINDOW_SIZE-1:0]      keep;
    // pos[i] counts survivors below slot i, pos[WINDOW_SIZE] is the total
    logic [CNT_W-1:0]            pos [WINDOW_SIZE+1];

    logic [WINDOW_SIZE-1:0]      nxt_valid;
    iw_entry_t [WINDOW_SIZE-1:0] nxt_slot;

    iw_entry_t                   dec_slot;
    logic                        dec_kill;
    logic                        enq;

    // removal: issued entry and anything in a flushed context
    assign pos[0] = '0;
    for (genvar i = 0; i < WINDOW_SIZE; i++) begin : g_keep
        assign keep[i] = resolved[i].valid & ~issue_onehot[i]
                       & ~(hazard_valid & |(resolved[i].ctx & hazard_mask));
        assign pos[i+1] = pos[i] + CNT_W'(keep[i]);
    end

    // decoded entry as it lands in a slot
    always_comb begin
        dec_slot          = '0;
        dec_slot.valid    = 1'b1;
        dec_slot.opcode   = dec_entry.opcode;
        dec_slot.funct    = dec_entry.funct;
        dec_slot.imm      = dec_entry.imm;
        dec_slot.rs1_need = dec_entry.rs1_need;
        dec_slot.rs1_tag  = dec_entry.rs1_tag;
        dec_slot.rs2_need = dec_entry.rs2_need;
        dec_slot.rs2_tag  = dec_entry.rs2_tag;
        dec_slot.rd_need  = dec_entry.rd_need;
        dec_slot.rd_tag   = dec_entry.rd_tag;
        dec_slot.ctx      = dec_entry.ctx;
        dec_slot.rs1_rdy  = ~dec_entry.rs1_need;
        dec_slot.rs2_rdy  = ~dec_entry.rs2_need;
        dec_slot.rd_rdy   = ~dec_entry.rd_need;
        // immediate ALU ops take the immediate as second operand
        if (dec_entry.opcode == OP_ALU_IMM) begin
            dec_slot.d_rs2 = dec_entry.imm;
        end
    end

    // an instruction already on a killed path never enters
    assign dec_kill = hazard_valid & |(dec_entry.ctx & hazard_mask);
    assign enq      = dec_valid & ~dec_kill & (pos[WINDOW_SIZE] < CNT_W'(WINDOW_SIZE));

    // compact survivors forward, then append the new entry
    always_comb begin
        nxt_valid = '0;
        nxt_slot  = slot_q;
        for (int i = 0; i < WINDOW_SIZE; i++) begin
            if (keep[i]) begin
                nxt_slot[pos[i][IDX_W-1:0]]  = resolved[i];
                nxt_valid[pos[i][IDX_W-1:0]] = 1'b1;
            end
        end
        if (enq) begin
            nxt_slot[pos[WINDOW_SIZE][IDX_W-1:0]]  = dec_slot;
            nxt_valid[pos[WINDOW_SIZE][IDX_W-1:0]] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= nxt_valid;
        end
    end

    always_ff @(posedge clk) begin
        slot_q <= nxt_slot;
    end

    // occupancy comes from valid_q alone
    always_comb begin
        for (int i = 0; i < WINDOW_SIZE; i++) begin
            slots[i]       = slot_q[i];
            slots[i].valid = valid_q[i];
        end
    end

    assign accept_able = ~valid_q[WINDOW_SIZE-1];

    // valid entries stay packed from slot 0
    a_packed: assert property (@(posedge clk) disable iff (!arst_n)
        (valid_q & (valid_q + WINDOW_SIZE'(1))) == '0);

    // decoder must respect the full indication
    a_dec_accept: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid |-> accept_able);

    // at most one issue per cycle, and only from a live slot
    a_issue_live: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(issue_onehot) && ((issue_onehot & ~valid_q) == '0));

endmodule

//--- verilog/inst_window.sv
`timescale 1ns/1ps

module inst_window
    import iw_pkg::*;
#(
    parameter int WINDOW_SIZE   = 8,
    parameter int RESOLVE_SLOTS = 4,
    parameter int ISSUE_SLOTS   = 2
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          dec_valid,
    input  dec_entry_t                    dec_entry,
    output logic                          accept_able,
    input  logic                          hazard_valid,
    input  logic [CTX_W-1:0]              hazard_mask,
    output reg_req_t  [RESOLVE_SLOTS-1:0] reg_req,
    input  reg_resp_t [RESOLVE_SLOTS-1:0] reg_resp,
    output logic                          issue_valid,
    output issue_op_t                     issue_op
);

    iw_entry_t [WINDOW_SIZE-1:0] slots;
    iw_entry_t [WINDOW_SIZE-1:0] resolved;
    logic [WINDOW_SIZE-1:0]      issue_onehot;

    // issue range sits inside the resolve range, which sits inside the window
    initial begin
        assert (ISSUE_SLOTS <= RESOLVE_SLOTS && RESOLVE_SLOTS <= WINDOW_SIZE)
            else $fatal(1, "inst_window: slot parameters out of order");
    end

    window_slots #(
        .WINDOW_SIZE (WINDOW_SIZE)
    ) u_slots (
        .clk          (clk),
        .arst_n       (arst_n),
        .resolved     (resolved),
        .issue_onehot (issue_onehot),
        .hazard_valid (hazard_valid),
        .hazard_mask  (hazard_mask),
        .dec_valid    (dec_valid),
        .dec_entry    (dec_entry),
        .slots        (slots),
        .accept_able  (accept_able)
    );

    operand_resolve #(
        .WINDOW_SIZE   (WINDOW_SIZE),
        .RESOLVE_SLOTS (RESOLVE_SLOTS)
    ) u_resolve (
        .slots    (slots),
        .reg_req  (reg_req),
        .reg_resp (reg_resp),
        .resolved (resolved)
    );

    issue_select #(
        .WINDOW_SIZE (WINDOW_SIZE),
        .ISSUE_SLOTS (ISSUE_SLOTS)
    ) u_select (
        .slots        (slots),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_onehot (issue_onehot)
    );

endmodule

//--- dv/tb_inst_window.sv
`timescale 1ns/1ps

module tb_inst_window
    import iw_pkg::*;
();

    localparam int WINDOW_SIZE    = 8;
    localparam int RESOLVE_SLOTS  = 4;
    localparam int TAGS           = 2 ** VREG_W;
    // directed tests run for about 150 cycles, limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                          clk;
    logic                          arst_n;
    logic                          dec_valid;
    dec_entry_t                    dec_entry;
    logic                          accept_able;
    logic                          hazard_valid;
    logic [CTX_W-1:0]              hazard_mask;
    reg_req_t  [RESOLVE_SLOTS-1:0] reg_req;
    reg_resp_t [RESOLVE_SLOTS-1:0] reg_resp;
    logic                          issue_valid;
    issue_op_t                     issue_op;

    // register manager model, one entry per virtual tag
    logic              tag_ready [TAGS];
    logic [WORD_W-1:0] tag_value [TAGS];
    logic [PREG_W-1:0] tag_pa    [TAGS];
    int                cycle_count = 0;

    inst_window #(
        .WINDOW_SIZE   (WINDOW_SIZE),
        .RESOLVE_SLOTS (RESOLVE_SLOTS),
        .ISSUE_SLOTS   (2)
    ) dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .dec_valid    (dec_valid),
        .dec_entry    (dec_entry),
        .accept_able  (accept_able),
        .hazard_valid (hazard_valid),
        .hazard_mask  (hazard_mask),
        .reg_req      (reg_req),
        .reg_resp     (reg_resp),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // replies in the same cycle as the request
    always_comb begin
        for (int i = 0; i < RESOLVE_SLOTS; i++) begin
            reg_resp[i].rs1_ready = tag_ready[reg_req[i].rs1_tag];
            reg_resp[i].rs1_value = tag_value[reg_req[i].rs1_tag];
            reg_resp[i].rs2_ready = tag_ready[reg_req[i].rs2_tag];
            reg_resp[i].rs2_value = tag_value[reg_req[i].rs2_tag];
            reg_resp[i].rd_ready  = tag_ready[reg_req[i].rd_tag];
            reg_resp[i].pa_rd     = tag_pa[reg_req[i].rd_tag];
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input logic [WORD_W-1:0] expected,
                         input logic [WORD_W-1:0] actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("Mismatch in %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    // compare an issued op against its decoded entry and resolved operands
    task automatic check_issue(input string name, input dec_entry_t e,
                               input logic [WORD_W-1:0] d_rs1, input logic [WORD_W-1:0] d_rs2,
                               input logic [PREG_W-1:0] pa_rd, input issue_op_t act);
        check({name, " opcode"}, WORD_W'(e.opcode), WORD_W'(act.opcode));
        check({name, " funct"}, WORD_W'(e.funct), WORD_W'(act.funct));
        check({name, " d_rs1"}, d_rs1, act.d_rs1);
        check({name, " d_rs2"}, d_rs2, act.d_rs2);
        check({name, " pa_rd"}, WORD_W'(pa_rd), WORD_W'(act.pa_rd));
        check({name, " ctx"}, WORD_W'(e.ctx), WORD_W'(act.ctx));
    endtask

    task automatic clear_tags();
        for (int t = 0; t < TAGS; t++) begin
            tag_ready[t] = 1'b0;
            tag_value[t] = $urandom;
            tag_pa[t]    = PREG_W'($urandom);
        end
    endtask

    function automatic dec_entry_t plain_entry(input opcode_t op, input logic [CTX_W-1:0] ctx);
        dec_entry_t e;
        e        = '0;
        e.opcode = op;
        e.funct  = FUNCT_W'($urandom);
        e.imm    = $urandom;
        e.ctx    = ctx;
        return e;
    endfunction

    // strobe one entry, return on the next falling edge
    task automatic push(input string name, input dec_entry_t e);
        if (!accept_able) begin
            stop_with_error($sformatf("%s: window refused an entry", name));
        end
        dec_valid = 1'b1;
        dec_entry = e;
        @(negedge clk);
        dec_valid = 1'b0;
    endtask

    task automatic wait_issue(input string name, input int limit, output issue_op_t op);
        int waited;
        waited = 0;
        while (!issue_valid) begin
            if (waited == limit) begin
                stop_with_error($sformatf("%s: no issue within %0d cycles", name, limit));
            end
            @(negedge clk);
            waited++;
        end
        op = issue_op;
        @(negedge clk);
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            check({name, " issue_valid"}, '0, WORD_W'(issue_valid));
            @(negedge clk);
        end
        check({name, " drained"}, '0, WORD_W'(reg_req[0].valid));
    endtask

    task automatic test_reset();
        check("reset issue_valid", '0, WORD_W'(issue_valid));
        check("reset accept_able", WORD_W'(1), WORD_W'(accept_able));
        for (int i = 0; i < RESOLVE_SLOTS; i++) begin
            check($sformatf("reset reg_req[%0d]", i), '0, WORD_W'(reg_req[i].valid));
        end
    endtask

    task automatic test_imm_alu();
        dec_entry_t e;
        issue_op_t  op;
        e = plain_entry(OP_ALU_IMM, 4'b0011);
        check("imm_alu idle", '0, WORD_W'(issue_valid));
        push("imm_alu", e);
        // no needs, so it goes out one cycle after the strobe
        check("imm_alu latency", WORD_W'(1), WORD_W'(issue_valid));
        wait_issue("imm_alu", 0, op);
        check_issue("imm_alu", e, '0, e.imm, '0, op);
        expect_quiet("imm_alu", 2);
    endtask

    task automatic test_resolve();
        dec_entry_t m;
        dec_entry_t a;
        issue_op_t  op;
        clear_tags();
        m          = plain_entry(OP_MEM, 4'b0001);
        m.rs1_need = 1'b1;
        m.rs1_tag  = 6'd5;
        m.rd_need  = 1'b1;
        m.rd_tag   = 6'd6;
        push("resolve mem", m);
        check("resolve mem rs1 request", WORD_W'(1), WORD_W'(reg_req[0].rs1_need));
        check("resolve mem rs2 request", '0, WORD_W'(reg_req[0].rs2_need));
        check("resolve mem rd request", WORD_W'(1), WORD_W'(reg_req[0].rd_need));
        for (int i = 0; i < 6; i++) begin
            check("resolve mem blocked", '0, WORD_W'(issue_valid));
            @(negedge clk);
        end
        tag_ready[5] = 1'b1;
        tag_ready[6] = 1'b1;
        wait_issue("resolve mem", 1, op);
        // memory ops carry base plus offset
        check_issue("resolve mem", m, tag_value[5] + m.imm, '0, tag_pa[6], op);
        a          = plain_entry(OP_ALU, 4'b0010);
        a.rs1_need = 1'b1;
        a.rs1_tag  = 6'd7;
        a.rs2_need = 1'b1;
        a.rs2_tag  = 6'd8;
        tag_ready[7] = 1'b1;
        tag_ready[8] = 1'b1;
        push("resolve alu", a);
        wait_issue("resolve alu", 1, op);
        check_issue("resolve alu", a, tag_value[7], tag_value[8], '0, op);
        expect_quiet("resolve", 2);
    endtask

    task automatic test_full_order();
        dec_entry_t ents [WINDOW_SIZE];
        issue_op_t  op;
        clear_tags();
        for (int i = 0; i < WINDOW_SIZE; i++) begin
            ents[i]         = plain_entry(OP_ALU_IMM, 4'b1000);
            ents[i].rd_need = 1'b1;
            ents[i].rd_tag  = 6'd10;
            push($sformatf("full push %0d", i), ents[i]);
        end
        check("full accept_able", '0, WORD_W'(accept_able));
        tag_ready[10] = 1'b1;
        // one issue per cycle once the shared tag is released
        for (int i = 0; i < WINDOW_SIZE; i++) begin
            wait_issue($sformatf("full issue %0d", i), (i == 0) ? 1 : 0, op);
            check_issue($sformatf("full issue %0d", i), ents[i], '0, ents[i].imm, tag_pa[10], op);
        end
        check("full accept_able again", WORD_W'(1), WORD_W'(accept_able));
        expect_quiet("full", 2);
    endtask

    task automatic test_age();
        dec_entry_t old_e;
        dec_entry_t young;
        issue_op_t  op;
        clear_tags();
        old_e          = plain_entry(OP_ALU, 4'b0001);
        old_e.rs1_need = 1'b1;
        old_e.rs1_tag  = 6'd20;
        young          = plain_entry(OP_ALU_IMM, 4'b0001);
        push("age old", old_e);
        push("age young", young);
        wait_issue("age young", 0, op);
        check_issue("age young", young, '0, young.imm, '0, op);
        for (int i = 0; i < 5; i++) begin
            check("age old blocked", '0, WORD_W'(issue_valid));
            @(negedge clk);
        end
        tag_ready[20] = 1'b1;
        wait_issue("age old", 1, op);
        check_issue("age old", old_e, tag_value[20], '0, '0, op);
        expect_quiet("age", 2);
    endtask

    task automatic test_flush();
        dec_entry_t ents [3];
        issue_op_t  op;
        clear_tags();
        for (int i = 0; i < 3; i++) begin
            ents[i]          = plain_entry(OP_ALU, CTX_W'(1 << i));
            ents[i].rs1_need = 1'b1;
            ents[i].rs1_tag  = VREG_W'(30 + i);
            push($sformatf("flush push %0d", i), ents[i]);
        end
        hazard_valid = 1'b1;
        hazard_mask  = 4'b0101;
        @(negedge clk);
        hazard_valid = 1'b0;
        // only the context 4'b0010 entry survives
        check("flush survivor", WORD_W'(1), WORD_W'(reg_req[0].valid));
        check("flush survivor ctx", WORD_W'(4'b0010), WORD_W'(reg_req[0].ctx));
        check("flush slot 1", '0, WORD_W'(reg_req[1].valid));
        tag_ready[30] = 1'b1;
        tag_ready[31] = 1'b1;
        tag_ready[32] = 1'b1;
        wait_issue("flush survivor", 1, op);
        check_issue("flush survivor", ents[1], tag_value[31], '0, '0, op);
        expect_quiet("flush", 20);
    endtask

    initial begin
        void'($urandom(32'hc459b398));
        arst_n       = 1'b0;
        dec_valid    = 1'b0;
        dec_entry    = '0;
        hazard_valid = 1'b0;
        hazard_mask  = '0;
        clear_tags();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_imm_alu();
        test_resolve();
        test_full_order();
        test_age();
        test_flush();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- sources.f
verilog/iw_pkg.sv
verilog/operand_resolve.sv
verilog/issue_select.sv
verilog/window_slots.sv
verilog/inst_window.sv
dv/tb_inst_window.sv

//--- run.sh
#!/bin/sh
# build and run the instruction window testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_inst_window -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
